// ==== rtl/iwmRegsPkg.sv ====
`default_nettype none

package iwmRegsPkg;

	// ========================================
	// State pseudo-register, indexed by addr[3:1]
	// ========================================
	localparam logic [2:0] swPhase0      = 3'd0;
	localparam logic [2:0] swPhase1      = 3'd1;
	localparam logic [2:0] swPhase2      = 3'd2;
	localparam logic [2:0] swPhase3      = 3'd3;
	localparam logic [2:0] swMotorOn     = 3'd4;
	localparam logic [2:0] swDriveSelect = 3'd5;
	localparam logic [2:0] swQ6          = 3'd6;
	localparam logic [2:0] swQ7          = 3'd7;

	// Mode register bit positions
	localparam int modeLatchBit    = 0;
	localparam int modeTimerOffBit = 2;
	localparam int modeFastBit     = 3;
	localparam int mode8MHzBit     = 4;

	// Latch, async and timer-off set out of reset
	localparam logic [7:0] modeResetValue = 8'h07;

	// Status byte, low five bits echo mode[4:0]
	localparam int statusSenseBit  = 7;
	localparam int statusEnableBit = 5;

	// Write handshake byte, underrun bit reads 1 when there is no underrun
	localparam int hsEmptyBit    = 7;
	localparam int hsUnderrunBit = 6;

endpackage

`default_nettype wire

// ==== rtl/iwmTimingPkg.sv ====
`default_nettype none

package iwmTimingPkg;

	// Width of every bit-cell counter
	localparam int cellCountWidth = 6;

	// ========================================
	// Bit-cell timing, index is {fast, 8MHz}
	// ========================================
	// Counters run at fclk in every mode
	// so the slow-mode values are doubled
	// 0 slow 7 MHz, 1 slow 8 MHz, 2 fast 7 MHz, 3 fast 8 MHz

	// Shortest gap that still counts as a 1
	localparam logic [cellCountWidth-1:0] oneThreshold [0:3] = '{
		6'd14, 6'd16, 6'd7, 6'd8
	};

	// One and a half cells without an edge gives a 0
	localparam logic [cellCountWidth-1:0] zeroThreshold [0:3] = '{
		6'd42, 6'd48, 6'd21, 6'd24
	};

	// Length of one written bit cell
	localparam logic [cellCountWidth-1:0] writeCell [0:3] = '{
		6'd28, 6'd32, 6'd14, 6'd16
	};

	// Motor-off delay, 2^23 + 100 fclk periods (about one second)
	localparam int motorOffDefault = (1 << 23) + 100;

endpackage

`default_nettype wire

// ==== rtl/iwmSwitches.sv ====
`timescale 1ns/1ns
`default_nettype none

module iwmSwitches (
	input  wire        fclk,
	input  wire        nRES,
	input  wire  [3:0] addr,
	input  wire        nDevSel,
	input  wire  [7:0] dataIn,
	input  wire  [7:0] readBuf,
	input  wire        sense,
	input  wire        enableActive,
	input  wire        bufEmpty,
	input  wire        noUnderrun,
	output logic [7:0] dataOut,
	output logic [3:0] phase,
	output logic       motorOn,
	output logic       driveSelect,
	output logic       q6,
	output logic       q7,
	output logic [7:0] mode,
	output logic       dataWrite,
	output logic       dataRead
);

	logic       nDevSelQ;
	logic       strobeDone;
	logic       windowStart;
	logic       writeSel;
	logic       modeWrite;
	logic [7:0] statusByte;
	logic [7:0] handshakeByte;

	// ========================================
	// Select window and access strobes
	// ========================================
	// First fclk edge of a low nDevSel window
	assign windowStart = ~nDevSel & nDevSelQ;

	// Register write slot, q7 q6 and A0 high
	// Only the first qualifying edge of a window counts
	assign writeSel  = ~nDevSel & ~strobeDone & q7 & q6 & addr[0];
	assign dataWrite = writeSel & motorOn;
	// Motor off turns the same slot into a mode write
	assign modeWrite = writeSel & ~motorOn;
	assign dataRead  = ~nDevSel & ~strobeDone & ~q7 & ~q6;

	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			nDevSelQ    <= 1'b1;
			strobeDone  <= 1'b0;
			phase       <= 4'b0000;
			motorOn     <= 1'b0;
			driveSelect <= 1'b0;
			q6          <= 1'b0;
			q7          <= 1'b0;
			mode        <= iwmRegsPkg::modeResetValue;
		end else begin
			nDevSelQ <= nDevSel;
			// Re-armed once the host lets go of nDevSel
			if (nDevSel) begin
				strobeDone <= 1'b0;
			end else if (dataWrite | modeWrite | dataRead) begin
				strobeDone <= 1'b1;
			end
			// A3-A1 pick the switch, A0 is its new level
			if (windowStart) begin
				case (addr[3:1])
					iwmRegsPkg::swPhase0:      phase[0]    <= addr[0];
					iwmRegsPkg::swPhase1:      phase[1]    <= addr[0];
					iwmRegsPkg::swPhase2:      phase[2]    <= addr[0];
					iwmRegsPkg::swPhase3:      phase[3]    <= addr[0];
					iwmRegsPkg::swMotorOn:     motorOn     <= addr[0];
					iwmRegsPkg::swDriveSelect: driveSelect <= addr[0];
					iwmRegsPkg::swQ6:          q6          <= addr[0];
					iwmRegsPkg::swQ7:          q7          <= addr[0];
				endcase
			end
			if (modeWrite) begin
				mode <= dataIn;
			end
		end
	end

	// ========================================
	// Host read multiplexer
	// ========================================
	always_comb begin
		statusByte = {3'b000, mode[4:0]};
		statusByte[iwmRegsPkg::statusSenseBit]  = sense;
		statusByte[iwmRegsPkg::statusEnableBit] = enableActive;
		handshakeByte = 8'h00;
		handshakeByte[iwmRegsPkg::hsEmptyBit]    = bufEmpty;
		handshakeByte[iwmRegsPkg::hsUnderrunBit] = noUnderrun;
		case ({q7, q6})
			2'b00:   dataOut = readBuf;
			2'b01:   dataOut = statusByte;
			2'b10:   dataOut = handshakeByte;
			default: dataOut = 8'hFF;
		endcase
	end

	// Data write leaves the mode register alone
	dataWriteKeepsMode: assert property (@(posedge fclk) disable iff (!nRES)
		dataWrite |=> $stable(mode))
		else $error("mode register changed on a data write");

endmodule

`default_nettype wire

// ==== rtl/iwmDriveEnable.sv ====
`timescale 1ns/1ns
`default_nettype none

module iwmDriveEnable #(
	parameter int motorOffCycles = iwmTimingPkg::motorOffDefault
) (
	input  wire  fclk,
	input  wire  nRES,
	input  wire  motorOn,
	input  wire  driveSelect,
	input  wire  q7,
	input  wire  timerOff,
	input  wire  noUnderrun,
	output logic nEnbl1,
	output logic nEnbl2,
	output logic nWrReq,
	output logic enableActive
);

	localparam int countWidth = $clog2(motorOffCycles + 1);
	localparam logic [countWidth-1:0] lastCount = countWidth'(motorOffCycles - 1);

	logic                  motorOnQ;
	logic                  timerActive;
	logic                  timerDrive;
	logic [countWidth-1:0] offCount;
	logic                  startTimer;
	logic                  holdOn;
	logic                  holdDrive;

	// ========================================
	// Motor-off timer
	// ========================================
	// Falling motorOn starts the timer unless mode disables it
	assign startTimer = motorOnQ & ~motorOn & ~timerOff;
	// Keep the enable low through the start cycle as well
	assign holdOn     = motorOn | timerActive | startTimer;
	// Drive latched at the falling edge wins while the timer runs
	assign holdDrive  = (motorOn | startTimer) ? driveSelect : timerDrive;

	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			motorOnQ    <= 1'b0;
			timerActive <= 1'b0;
			timerDrive  <= 1'b0;
			offCount    <= '0;
			nEnbl1      <= 1'b1;
			nEnbl2      <= 1'b1;
		end else begin
			motorOnQ <= motorOn;
			if (motorOn) begin
				// Motor back on cancels a pending turn-off
				timerActive <= 1'b0;
			end else if (startTimer) begin
				timerActive <= 1'b1;
				timerDrive  <= driveSelect;
				offCount    <= '0;
			end else if (timerActive) begin
				if (offCount == lastCount) begin
					timerActive <= 1'b0;
				end else begin
					offCount <= offCount + 1'b1;
				end
			end
			// Registered enables, one cycle behind motorOn
			nEnbl1 <= ~(holdOn & ~holdDrive);
			nEnbl2 <= ~(holdOn & holdDrive);
		end
	end

	assign enableActive = ~nEnbl1 | ~nEnbl2;

	// Write request needs q7, no underrun and a live drive
	assign nWrReq = ~(q7 & noUnderrun & enableActive);

	onlyOneDrive: assert property (@(posedge fclk) disable iff (!nRES)
		!(!nEnbl1 && !nEnbl2))
		else $error("both drive enables low");

endmodule

`default_nettype wire

// ==== rtl/iwmReadShifter.sv ====
`timescale 1ns/1ns
`default_nettype none

module iwmReadShifter (
	input  wire                                    fclk,
	input  wire                                    nRES,
	input  wire                                    rdData,
	input  wire                                    q7,
	input  wire                                    latchMode,
	input  wire                                    dataRead,
	input  wire  [iwmTimingPkg::cellCountWidth-1:0] oneThreshold,
	input  wire  [iwmTimingPkg::cellCountWidth-1:0] zeroThreshold,
	output logic [7:0]                             readBuf
);

	logic [1:0]                              rdSync;
	logic                                    rdPrev;
	logic                                    rdFall;
	logic [iwmTimingPkg::cellCountWidth-1:0] cellTimer;
	logic [7:0]                              shifter;
	logic [7:0]                              nextShift;
	logic [2:0]                              bitCount;
	logic                                    synced;
	logic                                    framed;
	logic                                    shiftOne;
	logic                                    shiftZero;

	// Two-stage synchroniser, rdPrev for the edge
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			rdSync <= 2'b11;
			rdPrev <= 1'b1;
		end else begin
			rdSync <= {rdSync[0], rdData};
			rdPrev <= rdSync[1];
		end
	end

	// Falling edge on the drive data is a 1
	assign rdFall    = rdPrev & ~rdSync[1];
	// Edges that come too early are dropped
	assign shiftOne  = rdFall & (cellTimer >= oneThreshold);
	assign shiftZero = ~rdFall & (cellTimer >= zeroThreshold);
	assign nextShift = {shifter[6:0], shiftOne};
	// Latch mode after a $FF, bytes every 8 bits
	assign framed    = latchMode & synced;

	// ========================================
	// Cell timer, shifter and byte framing
	// ========================================
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			cellTimer <= '0;
			shifter   <= 8'h00;
			bitCount  <= 3'd0;
			synced    <= 1'b0;
			readBuf   <= 8'h00;
		end else if (q7) begin
			// Write mode, the next read re-syncs on a leading $FF
			synced <= 1'b0;
		end else begin
			// Host read of the data register
			if (dataRead) begin
				readBuf[7] <= 1'b0;
			end
			if (rdFall) begin
				cellTimer <= '0;
			end else if (shiftZero) begin
				// Next 0 comes one full cell later
				cellTimer <= oneThreshold;
			end else begin
				cellTimer <= cellTimer + 1'b1;
			end
			if (shiftOne | shiftZero) begin
				if (framed) begin
					if (bitCount == 3'd7) begin
						readBuf <= nextShift;
						shifter <= 8'h00;
					end else begin
						shifter <= nextShift;
					end
					// Wraps to 0 after the eighth bit
					bitCount <= bitCount + 1'b1;
				end else if (latchMode && nextShift == 8'hFF) begin
					// Sync byte found
					readBuf  <= 8'hFF;
					shifter  <= 8'h00;
					bitCount <= 3'd0;
					synced   <= 1'b1;
				end else if (nextShift[7]) begin
					// GCR framing on MSB
					readBuf <= nextShift;
					shifter <= 8'h00;
				end else begin
					shifter <= nextShift;
				end
			end
		end
	end

	readBufHeldInWrite: assert property (@(posedge fclk) disable iff (!nRES)
		q7 |=> $stable(readBuf))
		else $error("read buffer changed in write mode");

endmodule

`default_nettype wire

// ==== rtl/iwmWriteShifter.sv ====
`timescale 1ns/1ns
`default_nettype none

module iwmWriteShifter (
	input  wire                                    fclk,
	input  wire                                    nRES,
	input  wire                                    q7,
	input  wire                                    dataWrite,
	input  wire  [7:0]                             dataIn,
	input  wire  [iwmTimingPkg::cellCountWidth-1:0] writeCell,
	output logic                                   wrData,
	output logic                                   bufEmpty,
	output logic                                   noUnderrun
);

	logic [7:0]                              writeBuf;
	logic [7:0]                              shifter;
	logic [iwmTimingPkg::cellCountWidth-1:0] cellTimer;
	logic [2:0]                              bitCount;
	logic                                    q7Q;
	logic                                    cellEnd;

	// Host byte waiting for the serializer
	always_ff @(posedge fclk) begin
		if (dataWrite) begin
			writeBuf <= dataIn;
		end
	end

	assign cellEnd = (cellTimer == writeCell - 1'b1);

	// ========================================
	// Serializer
	// ========================================
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			q7Q        <= 1'b0;
			shifter    <= 8'h00;
			cellTimer  <= '0;
			bitCount   <= 3'd0;
			wrData     <= 1'b0;
			bufEmpty   <= 1'b1;
			noUnderrun <= 1'b1;
		end else begin
			q7Q <= q7;
			if (!q7) begin
				noUnderrun <= 1'b1;
			end else if (!q7Q) begin
				// Entering write mode, $FF preamble
				// timer at 2 avoids a runt first cell
				shifter   <= 8'hFF;
				cellTimer <= 6'd2;
				bitCount  <= 3'd0;
			end else begin
				if (cellEnd) begin
					cellTimer <= '0;
					bitCount  <= bitCount + 1'b1;
					if (bitCount == 3'd7) begin
						// Byte boundary, hand-off or underrun
						if (!bufEmpty) begin
							shifter  <= writeBuf;
							bufEmpty <= 1'b1;
						end else begin
							noUnderrun <= 1'b0;
						end
					end else begin
						shifter <= {shifter[6:0], 1'b0};
					end
				end else begin
					cellTimer <= cellTimer + 1'b1;
				end
				// A 1 is a transition early in the cell
				if (cellTimer == 6'd1 && shifter[7]) begin
					wrData <= ~wrData;
				end
			end
			// Host write last so a same-cycle byte is kept
			if (dataWrite) begin
				bufEmpty <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/iwm.sv ====
`timescale 1ns/1ns
`default_nettype none

module iwm #(
	parameter int motorOffCycles = iwmTimingPkg::motorOffDefault
) (
	input  wire       fclk,
	input  wire       nRES,
	input  wire [3:0] addr,
	input  wire       nDevSel,
	input  wire [7:0] dataIn,
	input  wire       sense,
	input  wire       rdData,
	output wire [7:0] dataOut,
	output wire       wrData,
	output wire [3:0] phase,
	output wire       nWrReq,
	output wire       nEnbl1,
	output wire       nEnbl2
);

	wire                                    motorOn;
	wire                                    driveSelect;
	wire                                    q7;
	wire [7:0]                              mode;
	wire                                    dataWrite;
	wire                                    dataRead;
	wire [7:0]                              readBuf;
	wire                                    enableActive;
	wire                                    bufEmpty;
	wire                                    noUnderrun;
	wire [1:0]                              speedSel;
	wire [iwmTimingPkg::cellCountWidth-1:0] oneThr;
	wire [iwmTimingPkg::cellCountWidth-1:0] zeroThr;
	wire [iwmTimingPkg::cellCountWidth-1:0] writeCell;

	// ========================================
	// Timing set from the mode register
	// ========================================
	assign speedSel  = {mode[iwmRegsPkg::modeFastBit], mode[iwmRegsPkg::mode8MHzBit]};
	assign oneThr    = iwmTimingPkg::oneThreshold[speedSel];
	assign zeroThr   = iwmTimingPkg::zeroThreshold[speedSel];
	assign writeCell = iwmTimingPkg::writeCell[speedSel];

	// q6 only steers the read mux inside the switch block
	iwmSwitches switches (
		.fclk(fclk), .nRES(nRES), .addr(addr), .nDevSel(nDevSel),
		.dataIn(dataIn), .readBuf(readBuf), .sense(sense),
		.enableActive(enableActive), .bufEmpty(bufEmpty), .noUnderrun(noUnderrun),
		.dataOut(dataOut), .phase(phase), .motorOn(motorOn),
		.driveSelect(driveSelect), .q6(), .q7(q7), .mode(mode),
		.dataWrite(dataWrite), .dataRead(dataRead)
	);

	iwmDriveEnable #(.motorOffCycles(motorOffCycles)) driveEnable (
		.fclk(fclk), .nRES(nRES), .motorOn(motorOn), .driveSelect(driveSelect),
		.q7(q7), .timerOff(mode[iwmRegsPkg::modeTimerOffBit]), .noUnderrun(noUnderrun),
		.nEnbl1(nEnbl1), .nEnbl2(nEnbl2), .nWrReq(nWrReq), .enableActive(enableActive)
	);

	iwmReadShifter readShifter (
		.fclk(fclk), .nRES(nRES), .rdData(rdData), .q7(q7),
		.latchMode(mode[iwmRegsPkg::modeLatchBit]), .dataRead(dataRead),
		.oneThreshold(oneThr), .zeroThreshold(zeroThr), .readBuf(readBuf)
	);

	iwmWriteShifter writeShifter (
		.fclk(fclk), .nRES(nRES), .q7(q7), .dataWrite(dataWrite), .dataIn(dataIn),
		.writeCell(writeCell), .wrData(wrData), .bufEmpty(bufEmpty),
		.noUnderrun(noUnderrun)
	);

endmodule

`default_nettype wire

// ==== tests/iwmTbTasks.svh ====
`ifndef IWM_TB_TASKS_SVH
`define IWM_TB_TASKS_SVH

// One Galois LFSR step, taps 32 22 2 1
function automatic logic [31:0] lfsrStep(input logic [31:0] state);
	logic [31:0] next;
	next = state >> 1;
	if (state[0]) begin
		next = next ^ 32'h80200003;
	end
	return next;
endfunction

// Eight steps, one per bit, MSB forced for a valid disk byte
task automatic nextDiskByte(output logic [7:0] value);
	int i;
	value = 8'h00;
	for (i = 0; i < 8; i++) begin
		value = {value[6:0], lfsrState[0]};
		lfsrState = lfsrStep(lfsrState);
	end
	value[7] = 1'b1;
endtask

// Host access, nDevSel low for three cycles
// early is sampled before the switch moves, late after it
task automatic busAccess(input logic [3:0] a, input logic [7:0] d,
	output logic [7:0] early, output logic [7:0] late);
	@(posedge fclk);
	addr    <= a;
	dataIn  <= d;
	nDevSel <= 1'b0;
	@(negedge fclk);
	early = dataOut;
	repeat (2) @(posedge fclk);
	@(negedge fclk);
	late = dataOut;
	@(posedge fclk);
	nDevSel <= 1'b1;
	@(posedge fclk);
endtask

// Slow 7 MHz cells of 28 fclk, a falling edge at the start of each 1
task automatic sendDiskByte(input logic [7:0] value);
	int i;
	for (i = 7; i >= 0; i--) begin
		if (value[i]) begin
			@(posedge fclk);
			rdData <= 1'b0;
			repeat (3) @(posedge fclk);
			rdData <= 1'b1;
			repeat (24) @(posedge fclk);
		end else begin
			repeat (28) @(posedge fclk);
		end
	end
endtask

// Write access on addr F, then one wrData sample per data cell
// Preamble cell 0 is 26 long, then 28 per cell, data starts 222 after the strobe
task automatic captureWrite(input logic [7:0] value, output logic [7:0] got,
	output logic reqLow);
	logic prev;
	int   i;
	@(posedge fclk);
	addr    <= 4'hF;
	dataIn  <= value;
	nDevSel <= 1'b0;
	repeat (2) @(posedge fclk);
	@(posedge fclk);
	nDevSel <= 1'b1;
	repeat (205) @(posedge fclk);
	@(negedge fclk);
	prev   = wrData;
	reqLow = ~nWrReq;
	for (i = 7; i >= 0; i--) begin
		repeat (28) @(posedge fclk);
		@(negedge fclk);
		// A toggle inside the cell is a 1
		got[i] = wrData ^ prev;
		prev   = wrData;
	end
endtask

`endif

// ==== tests/iwmTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module iwmTb;

	// Row kinds
	localparam logic [3:0] kSwitch = 4'd0;
	localparam logic [3:0] kRead   = 4'd1;
	localparam logic [3:0] kMode   = 4'd2;
	localparam logic [3:0] kDisk   = 4'd3;
	localparam logic [3:0] kSync   = 4'd4;
	localparam logic [3:0] kWrite  = 4'd5;
	localparam logic [3:0] kTimer  = 4'd6;
	localparam logic [3:0] kEnable = 4'd7;
	localparam int rowCount = 29;

	// ========================================
	// Operation table {kind, stimulus, expected}
	// ========================================
	// Disk and write rows with stimulus 00 take an LFSR byte
	// The FF read at F with q6 set and the motor off also writes 00 into mode
	localparam logic [19:0] opTable [0:rowCount-1] = '{
		{kRead, 8'h0D, 8'h87}, {kRead, 8'h0C, 8'h00},
		{kRead, 8'h0F, 8'hC0}, {kRead, 8'h0E, 8'h00},
		{kSwitch, 8'h01, 8'h01}, {kSwitch, 8'h03, 8'h03},
		{kSwitch, 8'h05, 8'h07}, {kSwitch, 8'h07, 8'h0F},
		{kSwitch, 8'h00, 8'h0E}, {kSwitch, 8'h02, 8'h0C},
		{kSwitch, 8'h04, 8'h08}, {kSwitch, 8'h06, 8'h00},
		{kRead, 8'h0D, 8'h87}, {kRead, 8'h0F, 8'hFF}, {kRead, 8'h0E, 8'h80},
		{kMode, 8'h14, 8'h94}, {kMode, 8'h00, 8'h80},
		{kDisk, 8'h00, 8'h00}, {kDisk, 8'h00, 8'h00},
		{kDisk, 8'h00, 8'h00}, {kDisk, 8'hC9, 8'hC9},
		{kMode, 8'h01, 8'h81}, {kSync, 8'h3F, 8'h3F}, {kMode, 8'h00, 8'h80},
		{kSwitch, 8'h09, 8'h00}, {kRead, 8'h0D, 8'hA0}, {kEnable, 8'h00, 8'h02},
		{kWrite, 8'h00, 8'h00},
		{kTimer, 8'h00, 8'h00}
	};

	logic        fclk;
	logic        nRES;
	logic [3:0]  addr;
	logic        nDevSel;
	logic [7:0]  dataIn;
	logic        sense;
	logic        rdData;
	wire  [7:0]  dataOut;
	wire         wrData;
	wire  [3:0]  phase;
	wire         nWrReq;
	wire         nEnbl1;
	wire         nEnbl2;

	logic [31:0] lfsrState;
	int          checks;
	int          mismatches;
	int          timeouts;

	iwm #(.motorOffCycles(200)) dut (
		.fclk(fclk), .nRES(nRES), .addr(addr), .nDevSel(nDevSel), .dataIn(dataIn),
		.sense(sense), .rdData(rdData), .dataOut(dataOut), .wrData(wrData),
		.phase(phase), .nWrReq(nWrReq), .nEnbl1(nEnbl1), .nEnbl2(nEnbl2)
	);

	`include "iwmTbTasks.svh"

	initial begin
		fclk = 1'b0;
		forever #4 fclk = ~fclk;
	end

	task automatic compareByte(input string what, input logic [7:0] got,
		input logic [7:0] exp);
		checks++;
		assert (got === exp)
		else begin
			mismatches++;
			$display("Mismatch at %0t: %s read %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic reportTimeout(input string what);
		timeouts++;
		$display("Timeout at %0t: %s did not happen in time", $time, what);
	endtask

	// Clears q6, sends one byte, then polls the data register for bit 7
	task automatic gcrRead(input logic [7:0] stim);
		logic [7:0] value;
		logic [7:0] early;
		logic [7:0] late;
		int         n;
		value = stim;
		if (stim == 8'h00) begin
			nextDiskByte(value);
		end
		busAccess(4'hC, 8'h00, early, late);
		sendDiskByte(value);
		n = 0;
		early = 8'h00;
		while (!early[7] && n < 20) begin
			busAccess(4'hC, 8'h00, early, late);
			n++;
		end
		if (!early[7]) begin
			reportTimeout("GCR byte latch");
		end
		compareByte("GCR data", early, value);
	endtask

	// Sync byte then one latch-mode byte, which may have bit 7 clear
	task automatic latchRead(input logic [7:0] stim, input logic [7:0] exp);
		logic [7:0] early;
		logic [7:0] late;
		int         n;
		busAccess(4'hC, 8'h00, early, late);
		sendDiskByte(8'hFF);
		sendDiskByte(stim);
		n = 0;
		early = 8'hFF;
		while (early == 8'hFF && n < 20) begin
			busAccess(4'hC, 8'h00, early, late);
			n++;
		end
		if (early == 8'hFF) begin
			reportTimeout("byte after sync");
		end
		compareByte("latch-mode data", early, exp);
	endtask

	task automatic serialWrite(input logic [7:0] stim);
		logic [7:0] value;
		logic [7:0] got;
		logic [7:0] early;
		logic [7:0] late;
		logic       reqLow;
		int         n;
		value = stim;
		if (stim == 8'h00) begin
			nextDiskByte(value);
		end
		busAccess(4'hD, 8'h00, early, late);
		captureWrite(value, got, reqLow);
		compareByte("written cells", got, value);
		compareByte("nWrReq low while writing", {7'b0, reqLow}, 8'h01);
		n = 0;
		@(negedge fclk);
		while (nWrReq !== 1'b1 && n < 300) begin
			@(negedge fclk);
			n++;
		end
		if (nWrReq !== 1'b1) begin
			reportTimeout("nWrReq rise on underrun");
		end
		// Handshake, empty set and underrun active
		busAccess(4'hC, 8'h00, early, late);
		compareByte("handshake after underrun", late, 8'h80);
		busAccess(4'hE, 8'h00, early, late);
	endtask

	// Counts fclk cycles from the motor-off access until nEnbl1 rises
	task automatic motorOffDelay();
		logic [7:0] early;
		logic [7:0] late;
		int         n;
		busAccess(4'h8, 8'h00, early, late);
		n = 4;
		@(negedge fclk);
		while (nEnbl1 !== 1'b1 && n < 400) begin
			@(posedge fclk);
			n++;
			@(negedge fclk);
		end
		if (nEnbl1 !== 1'b1) begin
			reportTimeout("drive enable release");
		end
		checks++;
		assert (n >= 190 && n <= 220)
		else begin
			mismatches++;
			$display("Mismatch at %0t: enable released after %0d cycles", $time, n);
		end
	endtask

	initial begin
		logic [7:0] early;
		logic [7:0] late;
		logic [3:0] kind;
		logic [7:0] stim;
		logic [7:0] exp;
		int         r;
		nRES       = 1'b0;
		addr       = 4'h0;
		nDevSel    = 1'b1;
		dataIn     = 8'h00;
		sense      = 1'b1;
		rdData     = 1'b1;
		lfsrState  = 32'hb82d5fa3;
		checks     = 0;
		mismatches = 0;
		timeouts   = 0;
		repeat (4) @(posedge fclk);
		nRES <= 1'b1;
		repeat (2) @(posedge fclk);
		@(negedge fclk);
		compareByte("pins after reset", {1'b0, nEnbl1, nEnbl2, nWrReq, phase}, 8'h70);

		for (r = 0; r < rowCount; r++) begin
			kind = opTable[r][19:16];
			stim = opTable[r][15:8];
			exp  = opTable[r][7:0];
			case (kind)
				kSwitch: begin
					busAccess(stim[3:0], 8'h00, early, late);
					compareByte("phase", {4'h0, phase}, exp);
				end
				kRead: begin
					busAccess(stim[3:0], 8'h00, early, late);
					compareByte("register read", late, exp);
				end
				kMode: begin
					// q6 on, q7 on with the byte, q7 off to read status
					busAccess(4'hD, 8'h00, early, late);
					busAccess(4'hF, stim, early, late);
					busAccess(4'hE, 8'h00, early, late);
					compareByte("status after mode write", late, exp);
				end
				kDisk:   gcrRead(stim);
				kSync:   latchRead(stim, exp);
				kWrite:  serialWrite(stim);
				kTimer:  motorOffDelay();
				default: begin
					@(negedge fclk);
					compareByte("drive enables", {6'b0, nEnbl2, nEnbl1}, exp);
				end
			endcase
		end

		$display("Checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+tests
rtl/iwmRegsPkg.sv
rtl/iwmTimingPkg.sv
rtl/iwmSwitches.sv
rtl/iwmDriveEnable.sv
rtl/iwmReadShifter.sv
rtl/iwmWriteShifter.sv
rtl/iwm.sv
tests/iwmTb.sv
